//--- Bender.yml
package:
  name: rv32i_core

sources:
  - verilog/core_cfg_pkg.sv
  - verilog/rv_isa_pkg.sv
  - verilog/reg_file.sv
  - verilog/instr_exec.sv
  - verilog/core_sequencer.sv
  - verilog/core_top.sv
  - target: test
    files:
      - tests/tb_core_mem.sv
      - tests/tb_core.sv

//--- all.f
verilog/core_cfg_pkg.sv
verilog/rv_isa_pkg.sv
verilog/reg_file.sv
verilog/instr_exec.sv
verilog/core_sequencer.sv
verilog/core_top.sv
tests/tb_core_mem.sv
tests/tb_core.sv

//--- tests/tb_core.sv
`timescale 1ns/1ps

module tb_core
    import core_cfg_pkg::*, rv_isa_pkg::*;
();

    typedef enum logic [2:0] {T_ALU, T_MEM, T_BRANCH, T_JUMP, T_CTRL} test_kind_e;

    // alt picks SUB or SRA and imm picks OP-IMM
    // rnd replaces a and b by random words
    typedef struct packed {
        test_kind_e kind;
        funct3_t    f3;
        logic       alt;
        logic       imm;
        logic       rnd;
        data_t      a;
        data_t      b;
    } test_row_t;

    localparam int    NUM_ROWS   = 27;
    localparam int    MAX_CYCLES = 400 * NUM_ROWS;
    localparam addr_t DATA_BASE  = 32'd512;

    test_row_t rows [NUM_ROWS] = '{
        '{T_ALU,    F3_ADD,  1'b0, 1'b0, 1'b1, 32'h0,         32'h0},
        '{T_ALU,    F3_ADD,  1'b1, 1'b0, 1'b0, 32'd5,         32'd7},
        '{T_ALU,    F3_SLT,  1'b0, 1'b0, 1'b0, 32'hffff_fffd, 32'd2},
        '{T_ALU,    F3_SLTU, 1'b0, 1'b0, 1'b0, 32'hffff_fffd, 32'd2},
        '{T_ALU,    F3_AND,  1'b0, 1'b0, 1'b1, 32'h0,         32'h0},
        '{T_ALU,    F3_OR,   1'b0, 1'b0, 1'b1, 32'h0,         32'h0},
        '{T_ALU,    F3_XOR,  1'b0, 1'b0, 1'b1, 32'h0,         32'h0},
        '{T_ALU,    F3_SLL,  1'b0, 1'b0, 1'b0, 32'h8000_0001, 32'h21},
        '{T_ALU,    F3_SRL,  1'b0, 1'b0, 1'b0, 32'h8000_0000, 32'd4},
        '{T_ALU,    F3_SRL,  1'b1, 1'b0, 1'b0, 32'h8000_0000, 32'd4},
        '{T_ALU,    F3_ADD,  1'b0, 1'b1, 1'b0, 32'd10,        32'hfff},
        '{T_ALU,    F3_SLT,  1'b0, 1'b1, 1'b0, 32'hffff_fff0, 32'd5},
        '{T_ALU,    F3_SLTU, 1'b0, 1'b1, 1'b0, 32'd5,         32'hfff},
        '{T_ALU,    F3_XOR,  1'b0, 1'b1, 1'b1, 32'h0,         32'h0},
        '{T_ALU,    F3_OR,   1'b0, 1'b1, 1'b1, 32'h0,         32'h0},
        '{T_ALU,    F3_AND,  1'b0, 1'b1, 1'b1, 32'h0,         32'h0},
        '{T_ALU,    F3_SLL,  1'b0, 1'b1, 1'b0, 32'd3,         32'd31},
        '{T_ALU,    F3_SRL,  1'b0, 1'b1, 1'b0, 32'hf000_0000, 32'd28},
        '{T_MEM,    F3_ADD,  1'b0, 1'b0, 1'b0, 32'h1234_5678, 32'hcafe_f00d},
        '{T_MEM,    F3_ADD,  1'b0, 1'b0, 1'b1, 32'h0,         32'h0},
        '{T_BRANCH, F3_BEQ,  1'b0, 1'b0, 1'b0, 32'h55,        32'h55},
        '{T_BRANCH, F3_BEQ,  1'b0, 1'b0, 1'b0, 32'd3,         32'd9},
        '{T_BRANCH, F3_BEQ,  1'b0, 1'b0, 1'b0, 32'hffff_fff0, 32'd1},
        '{T_BRANCH, F3_BEQ,  1'b0, 1'b0, 1'b1, 32'h0,         32'h0},
        '{T_JUMP,   F3_ADD,  1'b0, 1'b0, 1'b0, 32'h000a_b000, 32'h0},
        '{T_JUMP,   F3_ADD,  1'b0, 1'b0, 1'b1, 32'h0,         32'h0},
        '{T_CTRL,   F3_ADD,  1'b0, 1'b0, 1'b0, 32'h100,       32'h0}
    };

    funct3_t br_forms [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

    logic     clk = 1'b0;
    logic     rst;
    logic     clr;
    logic     ena;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    data_t    out_data;
    logic     out_en;
    logic     halt;

    // ena as the core saw it at the last rising edge
    logic     ena_q = 1'b0;

    instr_t prog [$];
    data_t  expect_q [$];
    int     out_idx   = 0;
    int     err_count = 0;
    int     cycle_cnt = 0;

    core_top u_core_top (
        .clk      (clk),
        .rst      (rst),
        .clr      (clr),
        .ena      (ena),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .out_data (out_data),
        .out_en   (out_en),
        .halt     (halt)
    );

    tb_core_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #4 clk = ~clk;

    task automatic check(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t ns: %s got %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic stop_run(input string why);
        err_count++;
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "%s", why);
    endtask

    // expected results from the RV32I definitions
    function automatic data_t alu_model(funct3_t f3, logic alt, data_t a, data_t b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SRL:  return alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(funct3_t f3, data_t a, data_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic instr_t itype_word(opcode_e op, funct3_t f3, reg_sel_t rd,
                                          reg_sel_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t rtype_word(funct7_t f7, funct3_t f3, reg_sel_t rd,
                                          reg_sel_t rs1, reg_sel_t rs2);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic instr_t store_word(reg_sel_t rs2, reg_sel_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic instr_t branch_word(funct3_t f3, reg_sel_t rs1, reg_sel_t rs2,
                                           logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic instr_t jal_word(reg_sel_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    // byte address of the next instruction to be appended
    function automatic addr_t next_addr();
        return RESET_PC + 4 * prog.size();
    endfunction

    // LUI plus ADDI with the upper part rounded for the sign of the low 12 bits
    task automatic load_const(reg_sel_t rd, data_t v);
        data_t hi;
        hi = v + 32'h800;
        prog.push_back({hi[31:12], rd, LUI});
        prog.push_back(itype_word(OPIMM, F3_ADD, rd, rd, v[11:0]));
    endtask

    // x31 holds OUT_ADDR and HALT_ADDR sits 4 above it
    task automatic emit_out(reg_sel_t rs);
        prog.push_back(store_word(rs, 5'd31, 12'd0));
    endtask

    task automatic build_program(test_row_t r, data_t a, data_t b);
        logic [11:0] imm12;
        addr_t       tgt;
        prog.delete();
        expect_q.delete();
        load_const(5'd31, OUT_ADDR);
        load_const(5'd1, a);
        load_const(5'd2, b);
        case (r.kind)
            T_ALU: begin
                if (r.imm) begin
                    imm12 = (r.f3 == F3_SLL || r.f3 == F3_SRL) ? {7'b0, b[4:0]} : b[11:0];
                    prog.push_back(itype_word(OPIMM, r.f3, 5'd3, 5'd1, imm12));
                    prog.push_back(itype_word(OPIMM, r.f3, 5'd0, 5'd1, imm12));
                    expect_q.push_back(alu_model(r.f3, 1'b0, a, {{20{imm12[11]}}, imm12}));
                end else begin
                    prog.push_back(rtype_word(r.alt ? FUNCT7_ALT : 7'b0, r.f3, 5'd3, 5'd1, 5'd2));
                    prog.push_back(rtype_word(r.alt ? FUNCT7_ALT : 7'b0, r.f3, 5'd0, 5'd1, 5'd2));
                    expect_q.push_back(alu_model(r.f3, r.alt, a, b));
                end
                emit_out(5'd3);
                emit_out(5'd0);
                expect_q.push_back(32'd0);
            end
            T_MEM: begin
                // same word reached through two base registers and then overwritten
                load_const(5'd4, DATA_BASE);
                prog.push_back(store_word(5'd1, 5'd4, 12'd8));
                prog.push_back(itype_word(OPIMM, F3_ADD, 5'd5, 5'd4, 12'd4));
                prog.push_back(itype_word(LOAD, 3'b010, 5'd3, 5'd5, 12'd4));
                emit_out(5'd3);
                prog.push_back(store_word(5'd1, 5'd4, 12'd16));
                prog.push_back(store_word(5'd2, 5'd4, 12'd16));
                prog.push_back(itype_word(LOAD, 3'b010, 5'd6, 5'd4, 12'd16));
                emit_out(5'd6);
                expect_q = '{a, b};
            end
            T_BRANCH: begin
                foreach (br_forms[i]) begin
                    prog.push_back(branch_word(br_forms[i], 5'd1, 5'd2, 13'd12));
                    prog.push_back(itype_word(OPIMM, F3_ADD, 5'd3, 5'd0, 12'h111));
                    prog.push_back(jal_word(5'd0, 21'd8));
                    prog.push_back(itype_word(OPIMM, F3_ADD, 5'd3, 5'd0, 12'h222));
                    emit_out(5'd3);
                    expect_q.push_back(branch_model(br_forms[i], a, b) ? 32'h222 : 32'h111);
                end
            end
            T_JUMP: begin
                // the store of x0 between jump and target must never run
                expect_q.push_back(next_addr() + 4);
                prog.push_back(jal_word(5'd5, 21'd8));
                emit_out(5'd0);
                emit_out(5'd5);
                tgt = next_addr() + 16;
                load_const(5'd8, tgt - 4);
                expect_q.push_back(next_addr() + 4);
                prog.push_back(itype_word(JALR, 3'b000, 5'd9, 5'd8, 12'd4));
                emit_out(5'd0);
                emit_out(5'd9);
                expect_q.push_back(next_addr() + {a[31:12], 12'b0});
                prog.push_back({a[31:12], 5'd10, AUIPC});
                emit_out(5'd10);
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    prog.push_back(itype_word(OPIMM, F3_ADD, 5'd1, 5'd1, 12'd1));
                    emit_out(5'd1);
                    expect_q.push_back(a + i + 1);
                end
            end
        endcase
        prog.push_back(store_word(5'd0, 5'd31, 12'd4));
        // only reached if the halt store failed to stop the core
        emit_out(5'd1);
    endtask

    task automatic run_row(test_row_t r);
        data_t a;
        data_t b;
        a = r.rnd ? data_t'($urandom()) : r.a;
        b = r.rnd ? data_t'($urandom()) : r.b;
        @(posedge clk);
        ena <= 1'b0;
        clr <= 1'b1;
        build_program(r, a, b);
        u_mem.fill_pattern();
        foreach (prog[i]) begin
            u_mem.mem[RESET_PC / 4 + i] = prog[i];
        end
        out_idx = 0;
        @(posedge clk);
        clr <= 1'b0;
        ena <= 1'b1;
        @(negedge clk);
        check(halt, 1'b0, "halt after clr");
        if (r.kind == T_CTRL) begin
            repeat (12) @(posedge clk);
            ena <= 1'b0;
            repeat (30) @(posedge clk);
            ena <= 1'b1;
        end
        while (!halt) begin
            @(posedge clk);
        end
        repeat (10) begin
            @(negedge clk);
            check(halt, 1'b1, "halt held");
        end
        check(out_idx, expect_q.size(), "output word count");
    endtask

    // output words are checked as they appear
    always @(negedge clk) begin
        if (out_en) begin
            if (!ena) begin
                stop_run("output strobe seen while ena was low");
            end else if (halt) begin
                stop_run("output strobe seen after the core halted");
            end else if (out_idx >= expect_q.size()) begin
                stop_run("more output words than the program should produce");
            end else begin
                check(out_data, expect_q[out_idx], "out_data");
                out_idx++;
            end
        end
    end

    // memory requests must follow the port rules
    always @(negedge clk) begin
        if (mem_req.rd_req && mem_req.wr_req) begin
            stop_run("read and write requests were issued in the same cycle");
        end else if (!ena_q && (mem_req.rd_req || mem_req.wr_req)) begin
            stop_run("memory request issued while ena was low");
        end
    end

    always @(posedge clk) begin
        ena_q     <= ena;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            stop_run("timeout, the test table did not finish in the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h4578_1cfb));
        rst = 1'b0;
        clr = 1'b0;
        ena = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tests/tb_core_mem.sv
`timescale 1ns/1ps

module tb_core_mem import core_cfg_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int DEPTH = 1024;

    data_t       mem [0:DEPTH-1];
    logic [9:0]  req_idx;
    logic [9:0]  pend_idx;
    logic        busy;
    int unsigned wait_cnt;
    int unsigned delay;

    // word index from the byte address
    assign req_idx = mem_req.addr[11:2];

    // background words that change with every address bit
    task automatic fill_pattern();
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'h6b00_0000 ^ (i * 32'h0009_e3b5);
        end
    endtask

    // one request at a time is acked 1 to 3 cycles after it is seen
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_rsp  <= '0;
            busy     <= 1'b0;
            wait_cnt <= 0;
            pend_idx <= '0;
        end else begin
            mem_rsp <= '0;
            if (busy) begin
                if (wait_cnt == 0) begin
                    mem_rsp.ack     <= 1'b1;
                    mem_rsp.rd_data <= mem[pend_idx];
                    busy            <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_req.rd_req || mem_req.wr_req) begin
                if (mem_req.wr_req) begin
                    mem[req_idx] <= mem_req.wr_data;
                end
                pend_idx <= req_idx;
                delay = $urandom_range(2, 0);
                if (delay == 0) begin
                    mem_rsp.ack     <= 1'b1;
                    mem_rsp.rd_data <= mem[req_idx];
                end else begin
                    busy     <= 1'b1;
                    wait_cnt <= delay - 1;
                end
            end
        end
    end

endmodule

//--- verilog/core_cfg_pkg.sv
package core_cfg_pkg;

    // datapath widths
    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;
    localparam int REG_SEL_WIDTH = 5;
    localparam int NUM_REGS      = 32;

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [REG_SEL_WIDTH-1:0] reg_sel_t;

    // first fetch after reset or clr
    localparam addr_t RESET_PC  = 32'd128;

    // memory-mapped store targets
    localparam addr_t OUT_ADDR  = 32'd1000000;
    localparam addr_t HALT_ADDR = 32'd1000004;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        COMPLETE,
        HALTED
    } phase_e;

    // rd_req and wr_req are single-cycle pulses
    typedef struct packed {
        addr_t addr;
        data_t wr_data;
        logic  rd_req;
        logic  wr_req;
    } mem_req_t;

    // rd_data only valid while ack is high
    typedef struct packed {
        data_t rd_data;
        logic  ack;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_LOAD,
        ACT_STORE,
        ACT_OUT,
        ACT_HALT
    } mem_action_e;

    typedef struct packed {
        logic        wr_en;
        reg_sel_t    wr_sel;
        data_t       wr_data;
        addr_t       next_pc;
        mem_action_e action;
        addr_t       mem_addr;
        data_t       store_data;
    } exec_result_t;

endpackage

//--- verilog/core_sequencer.sv
`timescale 1ns/1ps

module core_sequencer import core_cfg_pkg::*, rv_isa_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         clr,
    input  logic         ena,
    input  mem_rsp_t     mem_rsp,
    output mem_req_t     mem_req,
    output addr_t        pc,
    output instr_t       instr,
    input  exec_result_t result,
    output logic         wr_en,
    output reg_sel_t     wr_sel,
    output data_t        wr_data,
    output data_t        out_data,
    output logic         out_en,
    output logic         halt
);

    phase_e   phase;
    phase_e   phase_nxt;
    addr_t    pc_nxt;
    mem_req_t req_nxt;
    logic     ld_pend;
    logic     ld_pend_nxt;
    reg_sel_t ld_sel;
    reg_sel_t ld_sel_nxt;

    // an ack that lands while ena is low is kept until the core runs again
    logic  ack_hold;
    data_t data_hold;
    logic  rsp_ack;
    data_t rsp_data;

    assign rsp_ack  = mem_rsp.ack | ack_hold;
    assign rsp_data = ack_hold ? data_hold : mem_rsp.rd_data;
    assign instr    = rsp_data;
    assign out_data = result.store_data;
    assign halt     = (phase == HALTED);

    always_comb begin
        phase_nxt      = phase;
        pc_nxt         = pc;
        req_nxt        = mem_req;
        req_nxt.rd_req = 1'b0;
        req_nxt.wr_req = 1'b0;
        ld_pend_nxt    = ld_pend;
        ld_sel_nxt     = ld_sel;
        wr_en          = 1'b0;
        wr_sel         = result.wr_sel;
        wr_data        = result.wr_data;
        out_en         = 1'b0;
        if (ena) begin
            case (phase)
                FETCH: begin
                    req_nxt.addr   = pc;
                    req_nxt.rd_req = 1'b1;
                    phase_nxt      = DECODE;
                end
                DECODE: begin
                    if (rsp_ack) begin
                        case (result.action)
                            ACT_LOAD, ACT_STORE: begin
                                req_nxt.addr    = result.mem_addr;
                                req_nxt.wr_data = result.store_data;
                                req_nxt.rd_req  = (result.action == ACT_LOAD);
                                req_nxt.wr_req  = (result.action == ACT_STORE);
                                ld_pend_nxt     = (result.action == ACT_LOAD);
                                ld_sel_nxt      = result.wr_sel;
                                phase_nxt       = COMPLETE;
                            end
                            ACT_HALT: phase_nxt = HALTED;
                            default: begin
                                // register-only and output instructions fetch next_pc right away
                                wr_en          = result.wr_en;
                                out_en         = (result.action == ACT_OUT);
                                pc_nxt         = result.next_pc;
                                req_nxt.addr   = result.next_pc;
                                req_nxt.rd_req = 1'b1;
                            end
                        endcase
                    end
                end
                COMPLETE: begin
                    if (rsp_ack) begin
                        // stores only wait for the ack
                        wr_en          = ld_pend;
                        wr_sel         = ld_sel;
                        wr_data        = rsp_data;
                        pc_nxt         = pc + 32'd4;
                        req_nxt.addr   = pc + 32'd4;
                        req_nxt.rd_req = 1'b1;
                        phase_nxt      = DECODE;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase    <= FETCH;
            pc       <= RESET_PC;
            mem_req  <= '0;
            ld_pend  <= 1'b0;
            ack_hold <= 1'b0;
        end else if (clr) begin
            phase    <= FETCH;
            pc       <= RESET_PC;
            mem_req  <= '0;
            ld_pend  <= 1'b0;
            ack_hold <= 1'b0;
        end else begin
            phase   <= phase_nxt;
            pc      <= pc_nxt;
            mem_req <= req_nxt;
            ld_pend <= ld_pend_nxt;
            if (!ena && mem_rsp.ack) begin
                ack_hold <= 1'b1;
            end else if (ena) begin
                ack_hold <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        ld_sel <= ld_sel_nxt;
        if (!ena && mem_rsp.ack) begin
            data_hold <= mem_rsp.rd_data;
        end
    end

    a_req_excl: assert property (@(posedge clk) disable iff (!rst)
        !(mem_req.rd_req && mem_req.wr_req));

    // no request is outstanding while fetching
    a_no_ack_in_fetch: assert property (@(posedge clk) disable iff (!rst)
        phase == FETCH |-> !mem_rsp.ack);

    a_no_write_halted: assert property (@(posedge clk) disable iff (!rst)
        phase == HALTED |-> !wr_en);

    // every decoded word must carry an opcode that instr_exec knows
    a_known_opcode: assert property (@(posedge clk) disable iff (!rst)
        (ena && phase == DECODE && rsp_ack) |->
            instr[6:0] inside {OPIMM, OP, LOAD, STORE, BRANCH, LUI, AUIPC, JAL, JALR});

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ps

module core_top import core_cfg_pkg::*, rv_isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     clr,
    input  logic     ena,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    output data_t    out_data,
    output logic     out_en,
    output logic     halt
);

    addr_t        pc;
    instr_t       instr;
    exec_result_t result;
    reg_sel_t     rs1_sel;
    reg_sel_t     rs2_sel;
    data_t        rs1_data;
    data_t        rs2_data;
    logic         wr_en;
    reg_sel_t     wr_sel;
    data_t        wr_data;

    core_sequencer u_core_sequencer (
        .clk      (clk),
        .rst      (rst),
        .clr      (clr),
        .ena      (ena),
        .mem_rsp  (mem_rsp),
        .mem_req  (mem_req),
        .pc       (pc),
        .instr    (instr),
        .result   (result),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data),
        .out_data (out_data),
        .out_en   (out_en),
        .halt     (halt)
    );

    // decode works straight off the fetched word
    instr_exec u_instr_exec (
        .instr    (instr),
        .pc       (pc),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (result)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

endmodule

//--- verilog/instr_exec.sv
`timescale 1ns/1ps

module instr_exec import core_cfg_pkg::*, rv_isa_pkg::*; (
    input  instr_t       instr,
    input  addr_t        pc,
    output reg_sel_t     rs1_sel,
    output reg_sel_t     rs2_sel,
    input  data_t        rs1_data,
    input  data_t        rs2_data,
    output exec_result_t result
);

    opcode_e  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    reg_sel_t rd_sel;

    data_t imm_i;
    data_t imm_s;
    data_t imm_b;
    data_t imm_u;
    data_t imm_j;

    data_t                   alu_a;
    data_t                   alu_b;
    data_t                   alu_out;
    logic [4:0]              shamt;
    logic signed [DATA_WIDTH-1:0] sra_val;
    logic                    alt_sel;
    logic                    alu_lt_s;
    logic                    alu_lt_u;

    logic br_eq;
    logic br_lt_s;
    logic br_lt_u;
    logic br_taken;

    addr_t pc_inc;
    addr_t load_addr;
    addr_t store_addr;
    addr_t jalr_sum;

    // instruction fields
    assign opcode  = opcode_e'(instr[6:0]);
    assign rd_sel  = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];
    assign funct7  = instr[31:25];

    // sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // OP-IMM takes its second operand from the immediate
    assign alu_a = rs1_data;
    assign alu_b = (opcode == OP) ? rs2_data : imm_i;
    assign shamt = alu_b[4:0];

    // instr[30] is an immediate bit in ADDI, so SUB is only decoded for OP
    assign alt_sel  = (funct7 == FUNCT7_ALT);
    assign sra_val  = $signed(alu_a) >>> shamt;
    assign alu_lt_s = $signed(alu_a) < $signed(alu_b);
    assign alu_lt_u = alu_a < alu_b;

    always_comb begin
        case (funct3)
            F3_ADD:  alu_out = (opcode == OP && alt_sel) ? alu_a - alu_b : alu_a + alu_b;
            F3_SLL:  alu_out = alu_a << shamt;
            F3_SLT:  alu_out = {31'b0, alu_lt_s};
            F3_SLTU: alu_out = {31'b0, alu_lt_u};
            F3_XOR:  alu_out = alu_a ^ alu_b;
            F3_SRL:  alu_out = alt_sel ? data_t'(sra_val) : alu_a >> shamt;
            F3_OR:   alu_out = alu_a | alu_b;
            default: alu_out = alu_a & alu_b;
        endcase
    end

    // branch compare always works on the two registers
    assign br_eq   = (rs1_data == rs2_data);
    assign br_lt_s = $signed(rs1_data) < $signed(rs2_data);
    assign br_lt_u = rs1_data < rs2_data;

    always_comb begin
        case (funct3)
            F3_BEQ:  br_taken = br_eq;
            F3_BNE:  br_taken = !br_eq;
            F3_BLT:  br_taken = br_lt_s;
            F3_BGE:  br_taken = !br_lt_s;
            F3_BLTU: br_taken = br_lt_u;
            F3_BGEU: br_taken = !br_lt_u;
            default: br_taken = 1'b0;
        endcase
    end

    assign pc_inc     = pc + 32'd4;
    assign load_addr  = rs1_data + imm_i;
    assign store_addr = rs1_data + imm_s;
    assign jalr_sum   = rs1_data + imm_i;

    always_comb begin
        result            = '0;
        result.wr_sel     = rd_sel;
        result.next_pc    = pc_inc;
        result.action     = ACT_NONE;
        result.mem_addr   = load_addr;
        result.store_data = rs2_data;
        case (opcode)
            OPIMM, OP: begin
                result.wr_en   = 1'b1;
                result.wr_data = alu_out;
            end
            LUI: begin
                result.wr_en   = 1'b1;
                result.wr_data = imm_u;
            end
            AUIPC: begin
                result.wr_en   = 1'b1;
                result.wr_data = pc + imm_u;
            end
            JAL: begin
                result.wr_en   = 1'b1;
                result.wr_data = pc_inc;
                result.next_pc = pc + imm_j;
            end
            JALR: begin
                result.wr_en   = 1'b1;
                result.wr_data = pc_inc;
                result.next_pc = {jalr_sum[31:1], 1'b0};
            end
            BRANCH: begin
                if (br_taken) begin
                    result.next_pc = pc + imm_b;
                end
            end
            LOAD: begin
                result.action = ACT_LOAD;
            end
            STORE: begin
                // output and halt are stores to fixed addresses
                result.mem_addr = store_addr;
                if (store_addr == OUT_ADDR) begin
                    result.action = ACT_OUT;
                end else if (store_addr == HALT_ADDR) begin
                    result.action = ACT_HALT;
                end else begin
                    result.action = ACT_STORE;
                end
            end
            default: result.action = ACT_HALT;
        endcase
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_cfg_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_sel_t rs1_sel,
    input  reg_sel_t rs2_sel,
    output data_t    rs1_data,
    output data_t    rs2_data,
    input  logic     wr_en,
    input  reg_sel_t wr_sel,
    input  data_t    wr_data
);

    // x0 has no storage
    data_t regs [1:NUM_REGS-1];

    // asynchronous read ports
    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // alu funct3 shared by OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // selects SUB over ADD and SRA over SRL
    localparam funct7_t FUNCT7_ALT = 7'b0100000;

endpackage
